//--- Makefile
# Verilator build and run of the logic-link endpoint testbench
TOP = lpif_link_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- lpif_auto_sync.sv
// Online sequencing for the logic-link endpoint
// Delays the tx and rx online levels by programmable cycle counts,
// generates the periodic strobe, gates the marker and builds the debug word
`timescale 1ns/1ns
`default_nettype none
`include "lpif_cfg.svh"

module lpif_auto_sync (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  logic [`LPIF_MRK_W-1:0]  tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  input  lpif_pkg::lpif_delay_t   delay_x_value,
  input  lpif_pkg::lpif_delay_t   delay_y_value,
  input  lpif_pkg::lpif_delay_t   delay_z_value,
  output logic                    tx_online_delay,
  output logic                    rx_online_delay,
  output logic                    tx_auto_mrk,
  output logic                    tx_auto_stb,
  output lpif_pkg::lpif_debug_t   debug_status
);
  import lpif_pkg::*;

  // Slot 0 is rx, slot 1 is tx
  logic              [1:0] online_in;
  lpif_delay_t [1:0]       online_lim;
  lpif_delay_t [1:0]       online_cnt;
  logic              [1:0] online_dly;

  lpif_stb_state_e stb_state;
  lpif_delay_t     stb_cnt;
  lpif_delay_t     stb_cnt_inc;

  //////////////////////////////////////////////////////////////////////
  // Online delay counters

  assign online_in     = {tx_online, rx_online};
  assign online_lim[0] = delay_x_value;
  assign online_lim[1] = delay_y_value;

  // Counter saturates at the limit and holds the delayed level high
  // Dropping the input clears both on the next edge
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (rst || !online_in[i]) begin
        online_cnt[i] <= '0;
        online_dly[i] <= 1'b0;
      end else if (online_cnt[i] >= online_lim[i]) begin
        online_dly[i] <= 1'b1;
      end else begin
        online_cnt[i] <= online_cnt[i] + lpif_delay_t'(1);
      end
    end
  end

  assign rx_online_delay = online_dly[0];
  assign tx_online_delay = online_dly[1];

  //////////////////////////////////////////////////////////////////////
  // Strobe generator

  assign stb_cnt_inc = stb_cnt + lpif_delay_t'(1);

  // Counts cycles since tx came online or since the last pulse
  // FIRE lasts one cycle, then the count restarts
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      stb_state <= STB_IDLE;
      stb_cnt   <= '0;
    end else if (!tx_online_delay) begin
      stb_state <= STB_IDLE;
      stb_cnt   <= '0;
    end else if (stb_cnt_inc >= delay_z_value) begin
      stb_state <= STB_FIRE;
      stb_cnt   <= '0;
    end else begin
      stb_state <= STB_COUNT;
      stb_cnt   <= stb_cnt_inc;
    end
  end

  // User bit forces the strobe, offline kills it
  assign tx_auto_stb = tx_online_delay & ((stb_state == STB_FIRE) | tx_stb_userbit);

  // Marker is any user marker bit while tx is up
  assign tx_auto_mrk = tx_online_delay & (|tx_mrk_userbit);

  //////////////////////////////////////////////////////////////////////
  // Debug status

  always_comb begin
    debug_status                 = '0;
    debug_status.tx_online_delay = tx_online_delay;
    debug_status.rx_online_delay = rx_online_delay;
  end

endmodule

`default_nettype wire

//--- lpif_cfg.svh
// Width and field position macros for the logic-link slave endpoint
// Included by the package and by every module that sizes a port or slices a PHY word
// PHY word layout is marker on top, strobe at the bottom, payload in between

`ifndef LPIF_CFG_SVH
`define LPIF_CFG_SVH

// User channel widths
`define LPIF_DATA_W    64
`define LPIF_STATE_W   4
`define LPIF_PROTID_W  4
`define LPIF_CRC_W     16

// PHY word geometry
`define LPIF_PHY_W     48
`define LPIF_PAYLOAD_W 46
`define LPIF_MRK_BIT   47
`define LPIF_STB_BIT   0

// Sequencing controls
`define LPIF_DELAY_W   16
// One marker user bit per quarter of the link
`define LPIF_MRK_W     4

`endif

//--- lpif_flit_pack.sv
// User channel side of the endpoint
// Registers the upstream user fields into a flit every cycle
// and spreads the received flit back onto the downstream user fields
`timescale 1ns/1ns
`default_nettype none

module lpif_flit_pack (
  input  logic                   clk_wr,
  input  logic                   rst,
  // Upstream user channel
  input  lpif_pkg::lpif_state_t  ustrm_state,
  input  lpif_pkg::lpif_protid_t ustrm_protid,
  input  lpif_pkg::lpif_data_t   ustrm_data,
  input  logic                   ustrm_dvalid,
  input  lpif_pkg::lpif_crc_t    ustrm_crc,
  input  logic                   ustrm_crc_valid,
  input  logic                   ustrm_valid,
  // Flits to and from the PHY side
  input  lpif_pkg::lpif_flit_t   rx_flit,
  output lpif_pkg::lpif_flit_t   tx_flit,
  // Downstream user channel
  output lpif_pkg::lpif_state_t  dstrm_state,
  output lpif_pkg::lpif_protid_t dstrm_protid,
  output lpif_pkg::lpif_data_t   dstrm_data,
  output logic                   dstrm_dvalid,
  output lpif_pkg::lpif_crc_t    dstrm_crc,
  output logic                   dstrm_crc_valid,
  output logic                   dstrm_valid
);
  import lpif_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Upstream capture

  // No handshake, a new flit is taken every cycle
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_flit <= '0;
    end else begin
      tx_flit.state     <= ustrm_state;
      tx_flit.protid    <= ustrm_protid;
      tx_flit.data      <= ustrm_data;
      tx_flit.dvalid    <= ustrm_dvalid;
      tx_flit.crc       <= ustrm_crc;
      tx_flit.crc_valid <= ustrm_crc_valid;
      tx_flit.valid     <= ustrm_valid;
      tx_flit.pad       <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Downstream delivery

  // rx_flit is already registered in the PHY block
  assign dstrm_state     = rx_flit.state;
  assign dstrm_protid    = rx_flit.protid;
  assign dstrm_data      = rx_flit.data;
  assign dstrm_dvalid    = rx_flit.dvalid;
  assign dstrm_crc       = rx_flit.crc;
  assign dstrm_crc_valid = rx_flit.crc_valid;
  assign dstrm_valid     = rx_flit.valid;

endmodule

`default_nettype wire

//--- lpif_link_properties.sv
// Concurrent checks on the endpoint top level
// Bound into every lpif_link_top instance, looks at PHY words, strobe and debug words
`timescale 1ns/1ns
`default_nettype none

module lpif_link_properties (
  input logic                     clk_wr,
  input logic                     rst,
  input logic                     tx_online_delay,
  input logic                     tx_auto_stb,
  input logic                     tx_stb_userbit,
  input lpif_pkg::lpif_phy_word_t tx_phy0,
  input lpif_pkg::lpif_phy_word_t tx_phy1,
  input lpif_pkg::lpif_debug_t    rx_downstream_debug_status,
  input lpif_pkg::lpif_debug_t    tx_upstream_debug_status
);
  import lpif_pkg::*;

  logic rsvd_clear;

  // Only the two online bits may be set in either status word
  assign rsvd_clear = (rx_downstream_debug_status.rsvd_hi == '0) &&
                      (rx_downstream_debug_status.rsvd_lo == '0) &&
                      (tx_upstream_debug_status.rsvd_hi == '0) &&
                      (tx_upstream_debug_status.rsvd_lo == '0);

  // Words registered from an offline cycle
  phy_zero_offline: assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online_delay |=> (tx_phy0 == '0) && (tx_phy1 == '0))
    else $error("PHY words not zero while tx is offline");

  // Periodic strobe is a single-cycle pulse
  stb_single_cycle: assert property (@(posedge clk_wr) disable iff (rst)
    (tx_auto_stb && !tx_stb_userbit) |=> (!tx_auto_stb || tx_stb_userbit))
    else $error("Strobe high two cycles in a row without the user bit");

  debug_rsvd_zero: assert property (@(posedge clk_wr) disable iff (rst) rsvd_clear)
    else $error("Debug status reserved bits not zero");

endmodule

bind lpif_link_top lpif_link_properties lpif_link_properties_i (
  .clk_wr                     (clk_wr),
  .rst                        (rst),
  .tx_online_delay            (tx_online_delay),
  .tx_auto_stb                (tx_auto_stb),
  .tx_stb_userbit             (tx_stb_userbit),
  .tx_phy0                    (tx_phy0),
  .tx_phy1                    (tx_phy1),
  .rx_downstream_debug_status (rx_downstream_debug_status),
  .tx_upstream_debug_status   (tx_upstream_debug_status)
);

`default_nettype wire

//--- lpif_link_tb.sv
// Testbench for the logic-link slave endpoint
// PHY words are looped back to the receive side. Runs reset, online delay,
// loopback, strobe, marker and receive-offline tests in sequence.
`timescale 1ns/1ns
`default_nettype none
`include "lpif_cfg.svh"

module lpif_link_tb;
  import lpif_pkg::*;

  // Whole run is about 330 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic                   clk_wr;
  logic                   rst;
  logic                   tx_online;
  logic                   rx_online;
  logic [`LPIF_MRK_W-1:0] tx_mrk_userbit;
  logic                   tx_stb_userbit;
  lpif_delay_t            delay_x_value;
  lpif_delay_t            delay_y_value;
  lpif_delay_t            delay_z_value;
  lpif_phy_word_t         tx_phy0;
  lpif_phy_word_t         tx_phy1;
  lpif_debug_t            rx_downstream_debug_status;
  lpif_debug_t            tx_upstream_debug_status;
  // User channels travel as flits
  lpif_flit_t             ustrm;
  lpif_flit_t             dstrm;

  // Scoreboard
  int         seed;
  int         cyc = 0;
  int         checks = 0;
  int         errors = 0;
  int         tests = 0;
  int         test_err_base = 0;
  string      test_name = "none";
  lpif_flit_t sent_q[$];
  int         due_q[$];

  //////////////////////////////////////////////////////////////////////
  // DUT with the PHY looped back

  lpif_link_top lpif_link_top_i (
    .*,
    .rx_phy0         (tx_phy0),
    .rx_phy1         (tx_phy1),
    .ustrm_state     (ustrm.state),
    .ustrm_protid    (ustrm.protid),
    .ustrm_data      (ustrm.data),
    .ustrm_dvalid    (ustrm.dvalid),
    .ustrm_crc       (ustrm.crc),
    .ustrm_crc_valid (ustrm.crc_valid),
    .ustrm_valid     (ustrm.valid),
    .dstrm_state     (dstrm.state),
    .dstrm_protid    (dstrm.protid),
    .dstrm_data      (dstrm.data),
    .dstrm_dvalid    (dstrm.dvalid),
    .dstrm_crc       (dstrm.crc),
    .dstrm_crc_valid (dstrm.crc_valid),
    .dstrm_valid     (dstrm.valid)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // Cycle count that also limits the run
  always @(posedge clk_wr) begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model

  // Flit layout as the user sees it with the pad bit zero
  function automatic lpif_flit_t make_flit(lpif_state_t st, lpif_protid_t pid,
                                           lpif_data_t d, logic dv, lpif_crc_t c,
                                           logic cv, logic v);
    lpif_flit_t f;
    f.state     = st;
    f.protid    = pid;
    f.data      = d;
    f.dvalid    = dv;
    f.crc       = c;
    f.crc_valid = cv;
    f.valid     = v;
    f.pad       = 1'b0;
    return f;
  endfunction

  // Low 46 flit bits on word 0 and high 46 on word 1 between marker and strobe
  function automatic lpif_phy_word_t expect_phy(lpif_flit_t f, bit hi, logic mrk, logic stb);
    logic [`LPIF_PAYLOAD_W-1:0] pay;
    pay = hi ? f[`LPIF_PAYLOAD_W +: `LPIF_PAYLOAD_W] : f[0 +: `LPIF_PAYLOAD_W];
    return {mrk, pay, stb};
  endfunction

  // No pad bit on the downstream ports
  function automatic lpif_flit_t observed_flit();
    lpif_flit_t f;
    f     = dstrm;
    f.pad = 1'b0;
    return f;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and helpers

  task automatic tally(bit ok, string values);
    checks++;
    if (!ok) begin
      errors++;
      $display("ERR %s: %s", test_name, values);
    end
  endtask

  task automatic check_flit(lpif_flit_t exp, lpif_flit_t act);
    tally(act === exp, $sformatf("flit expected %h, actual %h", exp, act));
  endtask

  task automatic check_phy(lpif_phy_word_t exp, lpif_phy_word_t act);
    tally(act === exp, $sformatf("phy word expected %h, actual %h", exp, act));
  endtask

  task automatic check_debug(lpif_debug_t exp, lpif_debug_t act);
    tally(act === exp, $sformatf("debug expected %h, actual %h", exp, act));
  endtask

  task automatic check_bit(logic exp, logic act);
    tally(act === exp, $sformatf("bit expected %b, actual %b", exp, act));
  endtask

  task automatic step();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic start_test(string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s done, %0d errors", test_name, errors - test_err_base);
  endtask

  task automatic random_flit(output lpif_flit_t f);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    f  = make_flit(r0[3:0], r0[7:4], {r1, r2}, r0[8], r0[31:16], r0[9], r0[10]);
  endtask

  task automatic wait_debug(lpif_debug_t want);
    int n;
    n = 0;
    while (tx_upstream_debug_status !== want && n < 32) begin
      step();
      n++;
    end
    if (tx_upstream_debug_status !== want) begin
      errors++;
      $display("%s: online levels did not come up in time", test_name);
    end
  endtask

  // Loopback delivery 3 cycles after each send
  always @(negedge clk_wr) begin
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      check_flit(sent_q.pop_front(), observed_flit());
      void'(due_q.pop_front());
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    lpif_flit_t  f;
    lpif_flit_t  fixed;
    lpif_debug_t want;
    logic        stb;
    seed           = 32'hf404360f;
    rst            = 1'b1;
    // Link fully enabled with zero delays so only reset holds the outputs low
    tx_online      = 1'b1;
    rx_online      = 1'b1;
    tx_mrk_userbit = '1;
    tx_stb_userbit = 1'b1;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    ustrm          = make_flit(4'h3, 4'hc, 64'hfeed_0bad_cafe_f00d,
                               1'b1, 16'h5a5a, 1'b1, 1'b1);
    repeat (4) @(posedge clk_wr);
    #1;
    rst = 1'b0;

    start_test("reset");
    check_phy('0, tx_phy0);
    check_phy('0, tx_phy1);
    check_flit('0, observed_flit());
    check_debug('0, rx_downstream_debug_status);
    check_debug('0, tx_upstream_debug_status);
    end_test();

    // Quiet link with the test delays
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = 16'd5;
    delay_y_value  = 16'd7;
    delay_z_value  = 16'd6;
    ustrm          = '0;
    step();

    // Delayed level rises on the edge after the count reaches its limit
    start_test("online");
    rx_online = 1'b1;
    tx_online = 1'b1;
    for (int k = 1; k <= 10; k++) begin
      step();
      want                 = '0;
      want.rx_online_delay = (k > int'(delay_x_value));
      want.tx_online_delay = (k > int'(delay_y_value));
      check_debug(want, rx_downstream_debug_status);
      check_debug(want, tx_upstream_debug_status);
    end
    rx_online = 1'b0;
    tx_online = 1'b0;
    step();
    check_debug('0, rx_downstream_debug_status);
    check_debug('0, tx_upstream_debug_status);
    end_test();

    start_test("loopback");
    rx_online            = 1'b1;
    tx_online            = 1'b1;
    want                 = '0;
    want.rx_online_delay = 1'b1;
    want.tx_online_delay = 1'b1;
    wait_debug(want);
    for (int i = 0; i < 200; i++) begin
      random_flit(f);
      ustrm = f;
      sent_q.push_back(f);
      due_q.push_back(cyc + 3);
      step();
    end
    repeat (4) step();
    if (due_q.size() != 0) begin
      errors++;
      $display("%s: %0d flits never reached the downstream side", test_name, due_q.size());
    end
    end_test();

    // Flit is held so whole PHY words are predictable
    start_test("strobe");
    fixed     = make_flit(4'ha, 4'h5, 64'h0123_4567_89ab_cdef, 1'b1, 16'hbeef, 1'b0, 1'b1);
    ustrm     = fixed;
    tx_online = 1'b0;
    step();
    tx_online = 1'b1;
    wait_debug(want);
    // Pulse z cycles after the rise shows on the PHY one cycle later
    for (int n = 1; n <= 20; n++) begin
      step();
      stb = (n > 1) && ((n - 1) % int'(delay_z_value) == 0);
      check_phy(expect_phy(fixed, 1'b0, 1'b0, stb), tx_phy0);
      check_phy(expect_phy(fixed, 1'b1, 1'b0, stb), tx_phy1);
    end
    tx_stb_userbit = 1'b1;
    repeat (6) begin
      step();
      check_bit(1'b1, tx_phy0[`LPIF_STB_BIT]);
      check_bit(1'b1, tx_phy1[`LPIF_STB_BIT]);
    end
    tx_stb_userbit = 1'b0;
    end_test();

    start_test("marker");
    for (int i = 0; i < 16; i++) begin
      tx_mrk_userbit = i[`LPIF_MRK_W-1:0];
      step();
      check_bit(|tx_mrk_userbit, tx_phy0[`LPIF_MRK_BIT]);
      check_bit(|tx_mrk_userbit, tx_phy1[`LPIF_MRK_BIT]);
    end
    tx_mrk_userbit = '0;
    end_test();

    // One edge drops the level and one more flushes the receive register
    start_test("rx_offline");
    rx_online = 1'b0;
    repeat (2) step();
    for (int i = 0; i < 12; i++) begin
      random_flit(f);
      ustrm          = f;
      tx_mrk_userbit = f.protid;
      step();
      check_flit('0, observed_flit());
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lpif_link_top.sv
// Top level of the logic-link slave endpoint
// User streaming channel in and out, two PHY words each way,
// online sequencing controls and two debug status words
`timescale 1ns/1ns
`default_nettype none
`include "lpif_cfg.svh"

module lpif_link_top (
  input  logic                     clk_wr,
  input  logic                     rst,
  // Control
  input  logic                     tx_online,
  input  logic                     rx_online,
  // PHY interconnect
  output lpif_pkg::lpif_phy_word_t tx_phy0,
  output lpif_pkg::lpif_phy_word_t tx_phy1,
  input  lpif_pkg::lpif_phy_word_t rx_phy0,
  input  lpif_pkg::lpif_phy_word_t rx_phy1,
  // Downstream channel
  output lpif_pkg::lpif_state_t    dstrm_state,
  output lpif_pkg::lpif_protid_t   dstrm_protid,
  output lpif_pkg::lpif_data_t     dstrm_data,
  output logic                     dstrm_dvalid,
  output lpif_pkg::lpif_crc_t      dstrm_crc,
  output logic                     dstrm_crc_valid,
  output logic                     dstrm_valid,
  // Upstream channel
  input  lpif_pkg::lpif_state_t    ustrm_state,
  input  lpif_pkg::lpif_protid_t   ustrm_protid,
  input  lpif_pkg::lpif_data_t     ustrm_data,
  input  logic                     ustrm_dvalid,
  input  lpif_pkg::lpif_crc_t      ustrm_crc,
  input  logic                     ustrm_crc_valid,
  input  logic                     ustrm_valid,
  // Debug status
  output lpif_pkg::lpif_debug_t    rx_downstream_debug_status,
  output lpif_pkg::lpif_debug_t    tx_upstream_debug_status,
  // Configuration
  input  logic [`LPIF_MRK_W-1:0]   tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  input  lpif_pkg::lpif_delay_t    delay_x_value,
  input  lpif_pkg::lpif_delay_t    delay_y_value,
  input  lpif_pkg::lpif_delay_t    delay_z_value
);
  import lpif_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Interconnect

  lpif_flit_t  tx_flit;
  lpif_flit_t  rx_flit;
  logic        tx_online_delay;
  logic        rx_online_delay;
  logic        tx_auto_mrk;
  logic        tx_auto_stb;
  lpif_debug_t debug_status;

  // Both directions report the same status word
  assign rx_downstream_debug_status = debug_status;
  assign tx_upstream_debug_status   = debug_status;

  //////////////////////////////////////////////////////////////////////
  // Sequencing, user side, PHY side

  lpif_auto_sync lpif_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_mrk     (tx_auto_mrk),
    .tx_auto_stb     (tx_auto_stb),
    .debug_status    (debug_status)
  );

  lpif_flit_pack lpif_flit_pack_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_flit         (rx_flit),
    .tx_flit         (tx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  // Sees the delayed online levels, never the raw ones
  lpif_phy_concat lpif_phy_concat_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_mrk     (tx_auto_mrk),
    .tx_auto_stb     (tx_auto_stb),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_flit         (rx_flit)
  );

endmodule

`default_nettype wire

//--- lpif_phy_concat.sv
// PHY side of the endpoint
// Splits a flit over two PHY words with marker and strobe inserted,
// and strips received words back into a flit
// Both directions are registered and held at zero while offline
`timescale 1ns/1ns
`default_nettype none
`include "lpif_cfg.svh"

module lpif_phy_concat (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  lpif_pkg::lpif_flit_t     tx_flit,
  input  logic                     tx_online_delay,
  input  logic                     rx_online_delay,
  input  logic                     tx_auto_mrk,
  input  logic                     tx_auto_stb,
  input  lpif_pkg::lpif_phy_word_t rx_phy0,
  input  lpif_pkg::lpif_phy_word_t rx_phy1,
  output lpif_pkg::lpif_phy_word_t tx_phy0,
  output lpif_pkg::lpif_phy_word_t tx_phy1,
  output lpif_pkg::lpif_flit_t     rx_flit
);
  import lpif_pkg::*;

  // Payload part of one PHY word
  typedef logic [`LPIF_PAYLOAD_W-1:0] payload_t;

  payload_t tx_pay0;
  payload_t tx_pay1;
  payload_t rx_pay0;
  payload_t rx_pay1;

  //////////////////////////////////////////////////////////////////////
  // Word layout helpers

  // Marker on top, strobe at the bottom, payload in between
  function automatic lpif_phy_word_t build_word(payload_t pay, logic mrk, logic stb);
    lpif_phy_word_t word;
    word                                     = '0;
    word[`LPIF_MRK_BIT]                      = mrk;
    word[`LPIF_STB_BIT]                      = stb;
    word[`LPIF_MRK_BIT-1:`LPIF_STB_BIT+1]    = pay;
    return word;
  endfunction

  function automatic payload_t strip_word(lpif_phy_word_t word);
    return word[`LPIF_MRK_BIT-1:`LPIF_STB_BIT+1];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Transmit

  // Low half of the flit rides on phy0, high half on phy1
  assign {tx_pay1, tx_pay0} = tx_flit;

  // Same marker and strobe on both words
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= build_word(tx_pay0, tx_auto_mrk, tx_auto_stb);
      tx_phy1 <= build_word(tx_pay1, tx_auto_mrk, tx_auto_stb);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Receive

  // Marker and strobe are dropped, only payloads are kept
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_delay) begin
      rx_pay0 <= '0;
      rx_pay1 <= '0;
    end else begin
      rx_pay0 <= strip_word(rx_phy0);
      rx_pay1 <= strip_word(rx_phy1);
    end
  end

  assign rx_flit = lpif_flit_t'({rx_pay1, rx_pay0});

endmodule

`default_nettype wire

//--- lpif_pkg.sv
// Shared types for the logic-link slave endpoint
// Flit, PHY word and debug word layouts plus the strobe FSM states
// Modules import it inside their body and use scoped names in port lists
`default_nettype none
`include "lpif_cfg.svh"

package lpif_pkg;

  // Plain vectors for the user fields
  typedef logic [`LPIF_DATA_W-1:0]   lpif_data_t;
  typedef logic [`LPIF_STATE_W-1:0]  lpif_state_t;
  typedef logic [`LPIF_PROTID_W-1:0] lpif_protid_t;
  typedef logic [`LPIF_CRC_W-1:0]    lpif_crc_t;
  typedef logic [`LPIF_DELAY_W-1:0]  lpif_delay_t;
  typedef logic [`LPIF_PHY_W-1:0]    lpif_phy_word_t;

  // One flit, 92 bits, fills exactly two PHY payloads
  // pad sits at bit 0 so the low payload starts with it
  typedef struct packed {
    lpif_state_t  state;
    lpif_protid_t protid;
    lpif_data_t   data;
    logic         dvalid;
    lpif_crc_t    crc;
    logic         crc_valid;
    logic         valid;
    logic         pad;
  } lpif_flit_t;

  // Debug status word, only the two online bits carry information
  typedef struct packed {
    logic [11:0] rsvd_hi;
    logic        tx_online_delay;
    logic        rx_online_delay;
    logic [17:0] rsvd_lo;
  } lpif_debug_t;

  // Strobe generator
  typedef enum logic [1:0] {STB_IDLE, STB_COUNT, STB_FIRE} lpif_stb_state_e;

endpackage

`default_nettype wire

//--- verilog.f
+incdir+.
lpif_pkg.sv
lpif_auto_sync.sv
lpif_flit_pack.sv
lpif_phy_concat.sv
lpif_link_top.sv
lpif_link_properties.sv
lpif_link_tb.sv
